//--- lock_pkg.sv
package lock_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int N_CH        = 4;                 // lock channels
	localparam int CH_W        = 2;                 // channel index bits
	localparam int ERR_W       = 16;                // signed error sample
	localparam int OUT_W       = 18;                // signed dac/dds word
	localparam int GAIN_W      = 8;                 // kp, ki, multiplier
	localparam int GAIN_SHIFT  = 4;                 // arithmetic shift after pi sum
	localparam int INTEG_W     = 32;                // wrapping integral
	localparam int SUM_W       = INTEG_W + GAIN_W + 2; // pi sum, no overflow
	localparam int CAND_W      = OUT_W + GAIN_W + 2;   // prev + scaled correction
	localparam int IN_DEPTH    = 2;                 // dispatcher queue entries
	localparam int IN_AW       = $clog2(IN_DEPTH);  // queue pointer bits
	localparam int OUT_CREDITS = 4;                 // downstream credits at reset
	localparam int CR_W        = $clog2(OUT_CREDITS + 1);

	// reset values of the active parameters
	localparam logic signed [OUT_W-1:0] DEF_MAX  = {1'b0, {(OUT_W-1){1'b1}}};
	localparam logic signed [OUT_W-1:0] DEF_MIN  = {1'b1, {(OUT_W-1){1'b0}}};
	localparam logic signed [OUT_W-1:0] DEF_INIT = '0;
	localparam logic [GAIN_W-1:0]       DEF_MULT = 8'd1;

	typedef struct packed {
		logic [CH_W-1:0]         channel;          // target lock channel
		logic signed [ERR_W-1:0] error;            // error signal sample
	} sample_t;

	typedef struct packed {
		logic [CH_W-1:0]         channel;          // source lock channel
		logic signed [OUT_W-1:0] value;            // output word
	} result_t;

	typedef enum logic [1:0] {
		CFG_BOUNDS   = 2'd0,                       // word holds window
		CFG_SETTINGS = 2'd1                        // word holds gains and init
	} cfg_kind_e;

	typedef struct packed {
		logic signed [OUT_W-1:0] out_max;          // upper bound, exclusive
		logic signed [OUT_W-1:0] out_min;          // lower bound, exclusive
		logic [7:0]              pad;
	} cfg_bounds_t;

	typedef struct packed {
		logic signed [OUT_W-1:0] out_init;         // fallback / constant value
		logic [GAIN_W-1:0]       multiplier;       // output scale
		logic [GAIN_W-1:0]       kp;
		logic [GAIN_W-1:0]       ki;
		logic                    lock_en;
		logic                    pad;
	} cfg_settings_t;

	// same 44 bits, decoded by kind
	typedef union packed {
		cfg_bounds_t   bounds;
		cfg_settings_t settings;
	} cfg_word_u;

	typedef struct packed {
		logic [CH_W-1:0] channel;                  // target lock channel
		cfg_kind_e       kind;                     // selects union view
		cfg_word_u       word;
	} cfg_t;

	typedef struct packed {
		logic signed [OUT_W-1:0] out_max;
		logic signed [OUT_W-1:0] out_min;
		logic signed [OUT_W-1:0] out_init;
		logic [GAIN_W-1:0]       multiplier;
		logic [GAIN_W-1:0]       kp;
		logic [GAIN_W-1:0]       ki;
		logic                    lock_en;
	} chan_cfg_t;

	localparam chan_cfg_t CFG_DEFAULT = '{
		out_max:    DEF_MAX,
		out_min:    DEF_MIN,
		out_init:   DEF_INIT,
		multiplier: DEF_MULT,
		kp:         '0,
		ki:         '0,
		lock_en:    1'b0
	};

	// preprocessor fsm, compute only lasts one cycle
	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_COMPUTE = 2'd1,
		ST_SEND    = 2'd2,
		ST_DONE    = 2'd3
	} pp_state_e;

endpackage

//--- pi_filter.sv
`timescale 1ns/1ps

module pi_filter (
	input  logic                                clk_in,
	input  logic                                reset_in,
	input  logic                                err_valid,   // new error sample
	input  logic signed [lock_pkg::ERR_W-1:0]   error,
	input  logic [lock_pkg::GAIN_W-1:0]         kp,          // unsigned prop gain
	input  logic [lock_pkg::GAIN_W-1:0]         ki,          // unsigned int gain
	input  logic                                clear,       // zero the integral
	output logic                                corr_valid,  // one cycle after err_valid
	output logic signed [lock_pkg::OUT_W-1:0]   correction
);

	logic signed [lock_pkg::INTEG_W-1:0] integral;    // running sum of errors
	logic signed [lock_pkg::INTEG_W-1:0] integ_next;  // sum including this sample
	logic signed [lock_pkg::SUM_W-1:0]   p_term;      // kp * error
	logic signed [lock_pkg::SUM_W-1:0]   i_term;      // ki * integral
	logic signed [lock_pkg::SUM_W-1:0]   sum;
	logic signed [lock_pkg::SUM_W-1:0]   shifted;     // sum after gain shift

	////////////////////////////////////////////////////////////////////////////
	// arithmetic
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		integ_next = integral + error;                      // wraps at 32 bits
		p_term     = $signed({1'b0, kp}) * error;           // gains zero-extended
		i_term     = $signed({1'b0, ki}) * integ_next;
		sum        = p_term + i_term;
		shifted    = sum >>> lock_pkg::GAIN_SHIFT;          // keeps sign
	end

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			integral   <= '0;
			corr_valid <= 1'b0;
		end else begin
			corr_valid <= err_valid;
			if (clear) begin
				integral <= '0;                             // settings write
			end else if (err_valid) begin
				integral <= integ_next;
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (err_valid) begin
			correction <= shifted[lock_pkg::OUT_W-1:0];     // low bits only, wraps
		end
	end

endmodule

//--- output_preprocessor.sv
`timescale 1ns/1ps

module output_preprocessor (
	input  logic                                clk_in,
	input  logic                                reset_in,
	input  logic                                corr_valid,  // correction from pi_filter
	input  logic signed [lock_pkg::OUT_W-1:0]   correction,
	input  lock_pkg::chan_cfg_t                 params,      // active channel parameters
	input  logic                                load_init,   // prev <= out_init
	output logic                                data_valid,  // held until take
	output logic signed [lock_pkg::OUT_W-1:0]   data,
	input  logic                                data_take
);

	lock_pkg::pp_state_e state_q;     // registered state
	lock_pkg::pp_state_e cur_state;   // compute decoded in the arrival cycle
	lock_pkg::pp_state_e next_state;

	logic signed [lock_pkg::OUT_W-1:0]  data_prev;   // last sent output
	logic signed [lock_pkg::CAND_W-1:0] scaled;      // correction * multiplier
	logic signed [lock_pkg::CAND_W-1:0] candidate;   // prev + scaled
	logic signed [lock_pkg::CAND_W-1:0] const_prod;  // out_init * multiplier
	logic                               in_range;
	logic signed [lock_pkg::OUT_W-1:0]  lock_out;
	logic signed [lock_pkg::OUT_W-1:0]  result;

	////////////////////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		scaled     = correction * $signed({1'b0, params.multiplier});
		candidate  = scaled + data_prev;                   // full width, no wrap
		const_prod = params.out_init * $signed({1'b0, params.multiplier});

		// strict window on both sides
		in_range = (candidate > $signed(params.out_min)) &&
			(candidate < $signed(params.out_max));

		lock_out = in_range ? candidate[lock_pkg::OUT_W-1:0] : params.out_init;
		result   = params.lock_en ? lock_out : const_prod[lock_pkg::OUT_W-1:0];
	end

	////////////////////////////////////////////////////////////////////////////
	// fsm
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		if ((state_q == lock_pkg::ST_IDLE) && corr_valid) begin
			cur_state = lock_pkg::ST_COMPUTE;              // result registered this cycle
		end else begin
			cur_state = state_q;
		end
	end

	always_comb begin
		next_state = cur_state;
		case (cur_state)
			lock_pkg::ST_IDLE:    next_state = lock_pkg::ST_IDLE;
			lock_pkg::ST_COMPUTE: next_state = lock_pkg::ST_SEND;
			lock_pkg::ST_SEND: begin
				if (data_take) begin
					next_state = lock_pkg::ST_DONE;         // collector took it
				end
			end
			lock_pkg::ST_DONE:    next_state = lock_pkg::ST_IDLE;
			default:              next_state = lock_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state_q <= lock_pkg::ST_IDLE;
		end else begin
			state_q <= next_state;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// output and history
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (cur_state == lock_pkg::ST_COMPUTE) begin
			data <= result;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			data_prev <= lock_pkg::DEF_INIT;
		end else if (load_init) begin
			data_prev <= params.out_init;                  // restart from init
		end else if (cur_state == lock_pkg::ST_DONE) begin
			data_prev <= data;                             // latch after take
		end
	end

	assign data_valid = (state_q == lock_pkg::ST_SEND);

endmodule

//--- lock_channel.sv
`timescale 1ns/1ps

module lock_channel #(
	parameter int unsigned CH_ID = 0                         // stamped on results
) (
	input  logic                clk_in,
	input  logic                reset_in,
	input  logic                ch_valid,   // sample from dispatcher
	input  lock_pkg::sample_t   ch_sample,
	input  logic                cfg_valid,  // write for this channel
	input  lock_pkg::cfg_t      cfg,
	output logic                res_valid,
	output lock_pkg::result_t   res,
	input  logic                res_take    // also the dispatcher credit
);

	lock_pkg::chan_cfg_t               cfg_q;       // active parameters
	logic                              load_q;      // settings written last cycle
	logic                              corr_valid;
	logic signed [lock_pkg::OUT_W-1:0] correction;
	logic signed [lock_pkg::OUT_W-1:0] data;

	// parameter registers, view picked by kind
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			cfg_q  <= lock_pkg::CFG_DEFAULT;
			load_q <= 1'b0;
		end else begin
			load_q <= cfg_valid && (cfg.kind == lock_pkg::CFG_SETTINGS);
			if (cfg_valid) begin
				case (cfg.kind)
					lock_pkg::CFG_BOUNDS: begin
						cfg_q.out_max <= cfg.word.bounds.out_max;
						cfg_q.out_min <= cfg.word.bounds.out_min;
					end
					lock_pkg::CFG_SETTINGS: begin
						cfg_q.out_init   <= cfg.word.settings.out_init;
						cfg_q.multiplier <= cfg.word.settings.multiplier;
						cfg_q.kp         <= cfg.word.settings.kp;
						cfg_q.ki         <= cfg.word.settings.ki;
						cfg_q.lock_en    <= cfg.word.settings.lock_en;
					end
					default: ;                             // unknown kind ignored
				endcase
			end
		end
	end

	pi_filter pi_filter_i (
		.clk_in     (clk_in),
		.reset_in   (reset_in),
		.err_valid  (ch_valid),
		.error      (ch_sample.error),
		.kp         (cfg_q.kp),
		.ki         (cfg_q.ki),
		.clear      (load_q),          // integral restarts with new settings
		.corr_valid (corr_valid),
		.correction (correction)
	);

	output_preprocessor output_preprocessor_i (
		.clk_in     (clk_in),
		.reset_in   (reset_in),
		.corr_valid (corr_valid),
		.correction (correction),
		.params     (cfg_q),
		.load_init  (load_q),          // new out_init already in cfg_q
		.data_valid (res_valid),
		.data       (data),
		.data_take  (res_take)
	);

	assign res.channel = CH_ID[lock_pkg::CH_W-1:0];
	assign res.value   = data;

endmodule

//--- sample_dispatcher.sv
`timescale 1ns/1ps

module sample_dispatcher (
	input  logic                       clk_in,
	input  logic                       reset_in,
	input  logic                       in_valid,      // source holds a credit
	input  lock_pkg::sample_t          in_sample,
	output logic                       in_credit,     // one per released sample
	input  logic                       cfg_valid,
	input  lock_pkg::cfg_t             cfg,
	output logic [lock_pkg::N_CH-1:0]  ch_valid,
	output lock_pkg::sample_t          ch_sample,     // shared by all channels
	output logic [lock_pkg::N_CH-1:0]  ch_cfg_valid,
	output lock_pkg::cfg_t             ch_cfg,
	input  logic [lock_pkg::N_CH-1:0]  ch_credit      // channel took its result
);

	lock_pkg::sample_t               fifo_mem [lock_pkg::IN_DEPTH];
	logic [lock_pkg::IN_AW-1:0]      wr_ptr;
	logic [lock_pkg::IN_AW-1:0]      rd_ptr;
	logic [lock_pkg::IN_AW:0]        count;       // entries held
	logic [lock_pkg::N_CH-1:0]       credit_q;    // one credit per channel
	lock_pkg::sample_t               head;
	logic                            pop;

	assign head = fifo_mem[rd_ptr];
	assign pop  = (count != '0) && credit_q[head.channel];  // head blocks the rest

	always_comb begin
		ch_valid = '0;
		if (pop) begin
			ch_valid[head.channel] = 1'b1;
		end
		ch_cfg_valid = '0;
		if (cfg_valid) begin
			ch_cfg_valid[cfg.channel] = 1'b1;       // one-hot by channel
		end
	end

	assign ch_sample = head;
	assign ch_cfg    = cfg;
	assign in_credit = pop;                          // slot freed this cycle

	////////////////////////////////////////////////////////////////////////////
	// queue and credits
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (in_valid) begin
			fifo_mem[wr_ptr] <= in_sample;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credit_q <= '1;                          // every channel idle
		end else begin
			if (in_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({in_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			credit_q <= (credit_q & ~ch_valid) | ch_credit;
		end
	end

endmodule

//--- output_collector.sv
`timescale 1ns/1ps

module output_collector (
	input  logic                       clk_in,
	input  logic                       reset_in,
	input  logic [lock_pkg::N_CH-1:0]  res_valid,
	input  lock_pkg::result_t          res [lock_pkg::N_CH],
	output logic [lock_pkg::N_CH-1:0]  res_take,     // grant, one hot
	output logic                       out_valid,
	output lock_pkg::result_t          out_result,
	input  logic                       out_credit    // sink freed a slot
);

	logic [lock_pkg::CH_W-1:0] rr_ptr;       // first channel to look at
	logic [lock_pkg::CR_W-1:0] credit_cnt;   // downstream credits held
	logic [lock_pkg::CH_W-1:0] idx;
	logic [lock_pkg::CH_W-1:0] gnt_idx;
	logic                      found;

	// round robin search from rr_ptr
	always_comb begin
		found    = 1'b0;
		gnt_idx  = rr_ptr;
		idx      = rr_ptr;
		res_take = '0;
		for (int k = 0; k < lock_pkg::N_CH; k++) begin
			idx = rr_ptr + k[lock_pkg::CH_W-1:0];      // wraps, N_CH is a power of 2
			if (!found && res_valid[idx] && (credit_cnt != '0)) begin
				found   = 1'b1;
				gnt_idx = idx;
			end
		end
		if (found) begin
			res_take[gnt_idx] = 1'b1;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			rr_ptr     <= '0;
			credit_cnt <= lock_pkg::CR_W'(lock_pkg::OUT_CREDITS);
			out_valid  <= 1'b0;
		end else begin
			out_valid <= found;
			if (found) begin
				rr_ptr <= gnt_idx + 1'b1;                // next one gets priority
			end
			case ({found, out_credit})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;       // both or neither
			endcase
		end
	end

	always_ff @(posedge clk_in) begin
		if (found) begin
			out_result <= res[gnt_idx];
		end
	end

endmodule

//--- lock_top.sv
`timescale 1ns/1ps

module lock_top (
	input  logic               clk_in,
	input  logic               reset_in,
	input  logic               in_valid,     // upstream sample
	input  lock_pkg::sample_t  in_sample,
	output logic               in_credit,    // credit back to source
	input  logic               cfg_valid,    // config write, no backpressure
	input  lock_pkg::cfg_t     cfg,
	output logic               out_valid,    // toward dac / dds
	output lock_pkg::result_t  out_result,
	input  logic               out_credit    // credit from sink
);

	logic [lock_pkg::N_CH-1:0] ch_valid;
	lock_pkg::sample_t         ch_sample;
	logic [lock_pkg::N_CH-1:0] ch_cfg_valid;
	lock_pkg::cfg_t            ch_cfg;
	logic [lock_pkg::N_CH-1:0] res_valid;
	lock_pkg::result_t         res [lock_pkg::N_CH];
	logic [lock_pkg::N_CH-1:0] res_take;     // doubles as channel credit

	sample_dispatcher sample_dispatcher_i (
		.clk_in       (clk_in),
		.reset_in     (reset_in),
		.in_valid     (in_valid),
		.in_sample    (in_sample),
		.in_credit    (in_credit),
		.cfg_valid    (cfg_valid),
		.cfg          (cfg),
		.ch_valid     (ch_valid),
		.ch_sample    (ch_sample),
		.ch_cfg_valid (ch_cfg_valid),
		.ch_cfg       (ch_cfg),
		.ch_credit    (res_take)
	);

	for (genvar i = 0; i < lock_pkg::N_CH; i++) begin : gen_ch
		lock_channel #(.CH_ID(i)) lock_channel_i (
			.clk_in    (clk_in),
			.reset_in  (reset_in),
			.ch_valid  (ch_valid[i]),
			.ch_sample (ch_sample),
			.cfg_valid (ch_cfg_valid[i]),
			.cfg       (ch_cfg),
			.res_valid (res_valid[i]),
			.res       (res[i]),
			.res_take  (res_take[i])
		);
	end

	output_collector output_collector_i (
		.clk_in     (clk_in),
		.reset_in   (reset_in),
		.res_valid  (res_valid),
		.res        (res),
		.res_take   (res_take),
		.out_valid  (out_valid),
		.out_result (out_result),
		.out_credit (out_credit)
	);

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 10,   // ns, 20 ns clock
	parameter int RESET_CYCLES = 3
) (
	output logic clk_in,
	output logic reset_in
);

	initial begin
		clk_in = 1'b0;
		forever #(HALF_PERIOD) clk_in = ~clk_in;
	end

	initial begin
		reset_in = 1'b1;                              // high from time 0
		repeat (RESET_CYCLES) @(posedge clk_in);
		reset_in <= 1'b0;                             // released on a rising edge
	end

endmodule

//--- lock_top_tb.sv
`timescale 1ns/1ps

module lock_top_tb;

	localparam int N_SAMPLES      = 12 + 40 + 32 + 24 + 20 + 48;  // all phases
	localparam int TIMEOUT_CYCLES = N_SAMPLES * 40 + 200;
	localparam int HOLD_CYCLES    = 80;                          // sink keeps its credits

	logic              clk_in;
	logic              reset_in;
	logic              in_valid   = 1'b0;
	lock_pkg::sample_t in_sample  = '0;
	logic              in_credit;
	logic              cfg_valid  = 1'b0;
	lock_pkg::cfg_t    cfg        = '0;
	logic              out_valid;
	lock_pkg::result_t out_result;
	logic              out_credit = 1'b0;

	logic [31:0] lfsr = 32'd27;                 // shared random state
	int          error_count = 0;
	int          cycle_count = 0;
	int          push_count  = 0;               // samples queued for the source
	int          recv_count  = 0;               // results seen at out_valid
	int          src_credits = 0;               // upstream credits held
	int          sink_fill   = 0;               // results parked in the sink
	logic        sink_hold   = 1'b0;            // sink returns no credits

	lock_pkg::sample_t send_q [$];
	lock_pkg::cfg_t    cfg_list [$];
	logic signed [lock_pkg::OUT_W-1:0] exp_q [lock_pkg::N_CH][$];   // per channel, in order

	// reference state per channel
	lock_pkg::chan_cfg_t                 m_cfg [lock_pkg::N_CH];
	logic signed [lock_pkg::INTEG_W-1:0] m_integ [lock_pkg::N_CH];
	logic signed [lock_pkg::OUT_W-1:0]   m_prev [lock_pkg::N_CH];

	tb_clock_gen tb_clock_gen_i (
		.clk_in   (clk_in),
		.reset_in (reset_in)
	);

	lock_top dut_i (
		.clk_in     (clk_in),
		.reset_in   (reset_in),
		.in_valid   (in_valid),
		.in_sample  (in_sample),
		.in_credit  (in_credit),
		.cfg_valid  (cfg_valid),
		.cfg        (cfg),
		.out_valid  (out_valid),
		.out_result (out_result),
		.out_credit (out_credit)
	);

	////////////////////////////////////////////////////////////////////////////
	// random numbers and failure reporting
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_next(lfsr);                    // one step per bit
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic signed [lock_pkg::ERR_W-1:0] rand_err(input int n);
		logic signed [31:0] v;
		v = take_bits(n) << (32 - n);
		return lock_pkg::ERR_W'(v >>> (32 - n));       // n-bit signed value
	endfunction

	task automatic end_with_failure();
		$display("Test FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_error(input string why);
		error_count++;
		$display("%s", why);
		end_with_failure();
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("FAILED %s: expected 0x%0h, got 0x%0h", name, expected, actual);
			end_with_failure();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model of filter and preprocessor
	////////////////////////////////////////////////////////////////////////////

	function automatic logic signed [lock_pkg::OUT_W-1:0] model_step(input int ch,
		input logic signed [lock_pkg::ERR_W-1:0] err);
		longint p_term;
		longint i_term;
		longint sum;
		longint cand;
		logic signed [lock_pkg::OUT_W-1:0] corr;
		logic signed [lock_pkg::OUT_W-1:0] out;
		m_integ[ch] = m_integ[ch] + err;                       // 32-bit wrap
		p_term = longint'(m_cfg[ch].kp) * longint'(err);
		i_term = longint'(m_cfg[ch].ki) * longint'(m_integ[ch]);
		sum    = (p_term + i_term) >>> lock_pkg::GAIN_SHIFT;
		corr   = sum[lock_pkg::OUT_W-1:0];                      // low bits, wraps
		if (m_cfg[ch].lock_en) begin
			cand = longint'(corr) * longint'(m_cfg[ch].multiplier) + longint'(m_prev[ch]);
			if ((cand > longint'(m_cfg[ch].out_min)) && (cand < longint'(m_cfg[ch].out_max))) begin
				out = cand[lock_pkg::OUT_W-1:0];
			end else begin
				out = m_cfg[ch].out_init;                      // outside window
			end
		end else begin
			cand = longint'(m_cfg[ch].out_init) * longint'(m_cfg[ch].multiplier);
			out  = cand[lock_pkg::OUT_W-1:0];                  // constant output
		end
		m_prev[ch] = out;
		return out;
	endfunction

	task automatic model_cfg(input lock_pkg::cfg_t c);
		if (c.kind == lock_pkg::CFG_BOUNDS) begin
			m_cfg[c.channel].out_max = c.word.bounds.out_max;
			m_cfg[c.channel].out_min = c.word.bounds.out_min;
		end else if (c.kind == lock_pkg::CFG_SETTINGS) begin
			m_cfg[c.channel].out_init   = c.word.settings.out_init;
			m_cfg[c.channel].multiplier = c.word.settings.multiplier;
			m_cfg[c.channel].kp         = c.word.settings.kp;
			m_cfg[c.channel].ki         = c.word.settings.ki;
			m_cfg[c.channel].lock_en    = c.word.settings.lock_en;
			m_prev[c.channel]           = c.word.settings.out_init;   // reload history
			m_integ[c.channel]          = '0;
		end
	endtask

	function automatic lock_pkg::cfg_t make_settings(input int ch,
		input logic signed [lock_pkg::OUT_W-1:0] init, input logic [7:0] mult,
		input logic [7:0] kp, input logic [7:0] ki, input logic en);
		lock_pkg::cfg_t c;
		c                     = '0;
		c.channel             = lock_pkg::CH_W'(ch);
		c.kind                = lock_pkg::CFG_SETTINGS;
		c.word.settings.out_init   = init;
		c.word.settings.multiplier = mult;
		c.word.settings.kp         = kp;
		c.word.settings.ki         = ki;
		c.word.settings.lock_en    = en;
		return c;
	endfunction

	function automatic lock_pkg::cfg_t make_bounds(input int ch,
		input logic signed [lock_pkg::OUT_W-1:0] hi, input logic signed [lock_pkg::OUT_W-1:0] lo);
		lock_pkg::cfg_t c;
		c                    = '0;
		c.channel            = lock_pkg::CH_W'(ch);
		c.kind               = lock_pkg::CFG_BOUNDS;
		c.word.bounds.out_max = hi;
		c.word.bounds.out_min = lo;
		return c;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers, called at the falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic push_sample(input int ch, input logic signed [lock_pkg::ERR_W-1:0] err);
		lock_pkg::sample_t s;
		s.channel = lock_pkg::CH_W'(ch);
		s.error   = err;
		exp_q[ch].push_back(model_step(ch, err));       // expected in channel order
		send_q.push_back(s);
		push_count++;
	endtask

	task automatic apply_cfg();
		lock_pkg::cfg_t c;
		while (cfg_list.size() != 0) begin
			c = cfg_list.pop_front();
			@(posedge clk_in);
			cfg_valid <= 1'b1;
			cfg       <= c;
			model_cfg(c);
		end
		@(posedge clk_in);
		cfg_valid <= 1'b0;
		repeat (3) @(negedge clk_in);                   // settle before new samples
	endtask

	task automatic drain_all();
		while ((send_q.size() != 0) || (recv_count != push_count)) begin
			@(negedge clk_in);
		end
		repeat (4) @(negedge clk_in);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// upstream source, sink and timeout
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk_in) begin
		if (reset_in) begin
			in_valid    <= 1'b0;
			src_credits = lock_pkg::IN_DEPTH;           // queue empty at reset
		end else begin
			if (in_credit) begin
				src_credits++;
			end
			if (src_credits > lock_pkg::IN_DEPTH) begin
				report_error("in_credit returned more credits than the source spent");
			end
			if ((src_credits > 0) && (send_q.size() != 0) && (take_bits(2) != 0)) begin
				in_valid    <= 1'b1;
				in_sample   <= send_q.pop_front();
				src_credits--;
			end else begin
				in_valid <= 1'b0;
			end
		end
	end

	always @(posedge clk_in) begin
		if (reset_in) begin
			out_credit <= 1'b0;
			sink_fill  = 0;
		end else begin
			if (out_valid) begin
				if (sink_fill >= lock_pkg::OUT_CREDITS) begin
					report_error("out_valid asserted while the sink had no free slot");
				end
				sink_fill++;
				if (exp_q[out_result.channel].size() == 0) begin
					report_error($sformatf("result on channel %0d with no sample outstanding",
						out_result.channel));
				end
				check_value($sformatf("out_result.value ch%0d", out_result.channel),
					32'(exp_q[out_result.channel].pop_front()), 32'(out_result.value));
				recv_count++;
			end
			if (!sink_hold && (sink_fill > 0) && (take_bits(1) != 0)) begin
				out_credit <= 1'b1;                     // slot freed in the sink
				sink_fill--;
			end else begin
				out_credit <= 1'b0;
			end
		end
	end

	always @(posedge clk_in) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			report_error($sformatf("timeout after %0d cycles, %0d of %0d results received",
				cycle_count, recv_count, push_count));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// test phases
	////////////////////////////////////////////////////////////////////////////

	initial begin : main
		int fill_start;
		int recv_start;
		for (int ch = 0; ch < lock_pkg::N_CH; ch++) begin
			m_cfg[ch]   = lock_pkg::CFG_DEFAULT;
			m_integ[ch] = '0;
			m_prev[ch]  = lock_pkg::DEF_INIT;
		end
		@(negedge clk_in);
		while (reset_in) begin
			@(negedge clk_in);
		end
		check_value("in_credit", 32'd0, 32'(in_credit));
		check_value("out_valid", 32'd0, 32'(out_valid));

		// defaults, constant zero output
		for (int k = 0; k < 12; k++) begin
			push_sample(int'(take_bits(2)), rand_err(16));
		end
		drain_all();

		// lock enabled on all channels, full window
		for (int ch = 0; ch < lock_pkg::N_CH; ch++) begin
			cfg_list.push_back(make_settings(ch, rand_err(10), 8'(1 + take_bits(2)),
				8'(take_bits(8)), 8'(take_bits(4)), 1'b1));
		end
		apply_cfg();
		for (int k = 0; k < 40; k++) begin
			push_sample(int'(take_bits(2)), rand_err(8));
		end
		drain_all();

		// narrow window around out_init
		for (int ch = 0; ch < lock_pkg::N_CH; ch++) begin
			cfg_list.push_back(make_bounds(ch, m_cfg[ch].out_init + 18'sd200,
				m_cfg[ch].out_init - 18'sd200));
		end
		apply_cfg();
		for (int k = 0; k < 32; k++) begin
			push_sample(int'(take_bits(2)), rand_err(10));
		end
		drain_all();

		// new settings on some channels, ch3 back to constant
		cfg_list.push_back(make_settings(0, rand_err(10), 8'(1 + take_bits(3)),
			8'(take_bits(6)), 8'(take_bits(3)), 1'b1));
		cfg_list.push_back(make_settings(2, rand_err(10), 8'(1 + take_bits(3)),
			8'(take_bits(6)), 8'(take_bits(3)), 1'b1));
		cfg_list.push_back(make_settings(3, rand_err(10), 8'(1 + take_bits(2)),
			8'(take_bits(6)), 8'(take_bits(3)), 1'b0));
		apply_cfg();
		for (int k = 0; k < 24; k++) begin
			push_sample(int'(take_bits(2)), rand_err(8));
		end
		drain_all();

		// sink withholds credits, only the credits it gave out may be used
		sink_hold  = 1'b1;
		fill_start = sink_fill;
		recv_start = recv_count;
		for (int k = 0; k < 20; k++) begin
			push_sample(int'(take_bits(2)), rand_err(8));
		end
		repeat (HOLD_CYCLES) @(negedge clk_in);
		check_value("results during credit hold", 32'(lock_pkg::OUT_CREDITS - fill_start),
			32'(recv_count - recv_start));
		sink_hold = 1'b0;
		drain_all();

		// interleaved over all channels
		for (int k = 0; k < 48; k++) begin
			push_sample(k % lock_pkg::N_CH, rand_err(8));
		end
		drain_all();

		if (error_count == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			end_with_failure();
		end
	end

endmodule

//--- filelist.f
lock_pkg.sv
pi_filter.sv
output_preprocessor.sv
lock_channel.sv
sample_dispatcher.sv
output_collector.sv
lock_top.sv
tb_clock_gen.sv
lock_top_tb.sv

//--- Bender.yml
package:
  name: lock_controller

sources:
  - lock_pkg.sv
  - pi_filter.sv
  - output_preprocessor.sv
  - lock_channel.sv
  - sample_dispatcher.sv
  - output_collector.sv
  - lock_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - lock_top_tb.sv
